/* src/fp_add_pkg.sv */
`default_nettype none

package fp_add_pkg;

  // Single-precision format
  localparam int unsigned frac_w = 23;
  localparam int unsigned exp_w = 8;
  localparam int unsigned word_w = 32;

  // Hidden bit, fraction and three guard bits
  localparam int unsigned ext_w = 27;

  localparam logic [exp_w-1:0] exp_max = 8'hff;

  // Round-mode bit values
  localparam logic round_nearest_even = 1'b0;
  localparam logic round_zero = 1'b1;

  typedef struct packed {
    logic              sign;
    logic [exp_w-1:0]  exp;
    logic [frac_w-1:0] frac;
  } fp_word_t;

  // Inexact sits in bit 0
  typedef struct packed {
    logic invalid;
    logic divide_by_zero;
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_t;

  typedef struct packed {
    logic [ext_w-1:0] mant_a;
    logic [ext_w-1:0] mant_b;
    logic [exp_w-1:0] exp;
    logic             sign_a;
    logic             sign_b;
    logic             round_mode;
  } fp_aligned_t;

  typedef struct packed {
    logic [ext_w-1:0] mant;
    logic             carry;
    logic [exp_w-1:0] exp;
    logic             sign;
    fp_flags_t        flags;
    logic             round_mode;
  } fp_stage_t;

endpackage

`default_nettype wire

/* src/fp_align.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_align import fp_add_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,

  input  wire         valid_in,
  input  wire         ready_in,
  input  wire fp_word_t op_a,
  input  wire fp_word_t op_b,
  input  wire         round_mode_in,

  output logic        valid_out,
  output logic        ready_out,
  output fp_aligned_t aligned
);

  logic [ext_w-1:0] mant_a_ext;
  logic [ext_w-1:0] mant_b_ext;
  logic             a_exp_larger;
  logic [exp_w-1:0] exp_diff;
  fp_aligned_t      aligned_next;

  // One item per stage, ready comes straight from downstream
  assign ready_out = ready_in;

  // Hidden one in front, zero guard bits behind
  assign mant_a_ext = {1'b1, op_a.frac, 3'b000};
  assign mant_b_ext = {1'b1, op_b.frac, 3'b000};

  assign a_exp_larger = op_a.exp >= op_b.exp;
  assign exp_diff = a_exp_larger ? op_a.exp - op_b.exp : op_b.exp - op_a.exp;

  always_comb begin
    aligned_next.sign_a = op_a.sign;
    aligned_next.sign_b = op_b.sign;
    aligned_next.round_mode = round_mode_in;

    // Shift of 27 or more leaves nothing
    if (a_exp_larger) begin
      aligned_next.exp = op_a.exp;
      aligned_next.mant_a = mant_a_ext;
      aligned_next.mant_b = mant_b_ext >> exp_diff;
    end else begin
      aligned_next.exp = op_b.exp;
      aligned_next.mant_a = mant_a_ext >> exp_diff;
      aligned_next.mant_b = mant_b_ext;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else if (ready_in) begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_in && ready_out) begin
      aligned <= aligned_next;
    end
  end

endmodule

`default_nettype wire

/* src/fp_addsub.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_addsub import fp_add_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,

  input  wire            valid_in,
  input  wire            ready_in,
  input  wire fp_aligned_t aligned,

  output logic           valid_out,
  output logic           ready_out,
  output fp_stage_t      sum
);

  logic             a_larger;
  logic [ext_w-1:0] mant_big;
  logic [ext_w-1:0] mant_small;
  logic             sign_big;
  fp_stage_t        sum_next;

  assign ready_out = ready_in;

  // Exponents already match, so the mantissas order the magnitudes
  assign a_larger = aligned.mant_a >= aligned.mant_b;
  assign mant_big = a_larger ? aligned.mant_a : aligned.mant_b;
  assign mant_small = a_larger ? aligned.mant_b : aligned.mant_a;
  assign sign_big = a_larger ? aligned.sign_a : aligned.sign_b;

  always_comb begin
    sum_next.exp = aligned.exp;
    sum_next.round_mode = aligned.round_mode;
    sum_next.flags = '0;

    if (aligned.sign_a == aligned.sign_b) begin
      {sum_next.carry, sum_next.mant} = {1'b0, aligned.mant_a} + {1'b0, aligned.mant_b};
      sum_next.sign = aligned.sign_a;
    end else begin
      // Larger minus smaller never borrows
      sum_next.mant = mant_big - mant_small;
      sum_next.carry = 1'b0;
      sum_next.sign = sign_big;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else if (ready_in) begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_in && ready_out) begin
      sum <= sum_next;
    end
  end

endmodule

`default_nettype wire

/* src/fp_normalize.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_normalize import fp_add_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,

  input  wire          valid_in,
  input  wire          ready_in,
  input  wire fp_stage_t in_stage,

  output logic         valid_out,
  output logic         ready_out,
  output fp_stage_t    out_stage
);

  logic      busy;
  logic      accept;
  fp_stage_t cur;

  fp_stage_t        load_stage;
  logic             load_done;
  logic [exp_w-1:0] exp_inc;

  fp_stage_t shift_stage;
  logic      shift_done;

  // Blocked while shifting or while the held result is still waiting
  assign ready_out = !busy && (!valid_out || ready_in);
  assign accept = valid_in && ready_out;

  assign exp_inc = in_stage.exp + 1'b1;

  // Value captured on acceptance
  always_comb begin
    load_stage = in_stage;
    load_stage.carry = 1'b0;

    if (in_stage.carry) begin
      load_stage.mant = {1'b1, in_stage.mant[ext_w-1:1]};
      load_stage.exp = exp_inc;
      if (in_stage.mant[0]) begin
        load_stage.flags.inexact = 1'b1;
      end
      if (exp_inc == exp_max) begin
        // Saturate to infinity
        load_stage.mant = '0;
        load_stage.flags.overflow = 1'b1;
        load_stage.flags.inexact = 1'b1;
      end
    end else if (in_stage.exp == '0) begin
      load_stage.flags.underflow = 1'b1;
      load_stage.flags.inexact = 1'b1;
    end
  end

  // Loop condition checked before any left shift
  assign load_done = in_stage.carry || in_stage.mant[ext_w-1] ||
                     in_stage.mant == '0 || in_stage.exp == '0;

  // One left shift per busy cycle
  always_comb begin
    shift_stage = cur;
    shift_stage.mant = cur.mant << 1;
    shift_stage.exp = cur.exp - 1'b1;
    if (shift_stage.exp == '0) begin
      shift_stage.flags.underflow = 1'b1;
      shift_stage.flags.inexact = 1'b1;
    end
  end

  assign shift_done = shift_stage.mant[ext_w-1] || shift_stage.mant == '0 ||
                      shift_stage.exp == '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      valid_out <= 1'b0;
    end else if (accept) begin
      busy <= !load_done;
      valid_out <= load_done;
    end else if (busy) begin
      busy <= !shift_done;
      valid_out <= shift_done;
    end else if (valid_out && ready_in) begin
      valid_out <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cur <= load_stage;
    end else if (busy) begin
      cur <= shift_stage;
    end
  end

  assign out_stage = cur;

endmodule

`default_nettype wire

/* src/fp_round.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_round import fp_add_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,

  input  wire          valid_in,
  input  wire          ready_in,
  input  wire fp_stage_t in_stage,

  output logic         valid_out,
  output logic         ready_out,
  output fp_stage_t    out_stage
);

  logic           last_bit;
  logic           round_bit;
  logic           sticky_bit;
  logic           round_up;
  logic [ext_w:0] mant_sum;
  fp_stage_t      stage_next;

  assign ready_out = ready_in;

  // Bit 3 is the last kept fraction bit
  assign last_bit = in_stage.mant[3];
  assign round_bit = in_stage.mant[2];
  assign sticky_bit = |in_stage.mant[1:0];

  always_comb begin
    case (in_stage.round_mode)
      round_nearest_even: round_up = round_bit && (sticky_bit || last_bit);
      round_zero:         round_up = 1'b0;
    endcase
  end

  // One unit in the last place
  assign mant_sum = {1'b0, in_stage.mant} + {{(ext_w - 3){1'b0}}, round_up, 3'b000};

  always_comb begin
    stage_next = in_stage;
    {stage_next.carry, stage_next.mant} = mant_sum;
    if (round_bit || sticky_bit) begin
      stage_next.flags.inexact = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else if (ready_in) begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_in && ready_out) begin
      out_stage <= stage_next;
    end
  end

endmodule

`default_nettype wire

/* src/fp_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_adder import fp_add_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,

  input  wire fp_word_t  op_a,
  input  wire fp_word_t  op_b,
  input  wire            round_mode,
  input  wire            start,
  input  wire            out_ready,

  output wire            in_ready,
  output wire            valid_out,
  output wire fp_word_t  result,
  output wire fp_flags_t flags
);

  fp_aligned_t aligned;
  fp_stage_t   sum_stage;
  fp_stage_t   norm_stage;
  fp_stage_t   round_stage;
  fp_stage_t   renorm_stage;

  logic align_valid;
  logic addsub_valid;
  logic norm_valid;
  logic round_valid;

  logic addsub_ready;
  logic norm_ready;
  logic round_ready;
  logic renorm_ready;

  logic             res_zero;
  logic [exp_w-1:0] res_exp;

  fp_align align (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_in     (start),
    .ready_in     (addsub_ready),
    .op_a         (op_a),
    .op_b         (op_b),
    .round_mode_in(round_mode),
    .valid_out    (align_valid),
    .ready_out    (in_ready),
    .aligned      (aligned)
  );

  fp_addsub addsub (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_in (align_valid),
    .ready_in (norm_ready),
    .aligned  (aligned),
    .valid_out(addsub_valid),
    .ready_out(addsub_ready),
    .sum      (sum_stage)
  );

  fp_normalize norm (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_in (addsub_valid),
    .ready_in (round_ready),
    .in_stage (sum_stage),
    .valid_out(norm_valid),
    .ready_out(norm_ready),
    .out_stage(norm_stage)
  );

  fp_round rounder (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_in (norm_valid),
    .ready_in (renorm_ready),
    .in_stage (norm_stage),
    .valid_out(round_valid),
    .ready_out(round_ready),
    .out_stage(round_stage)
  );

  // Only sees a rounding carry or an already normalized value
  fp_normalize renorm (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_in (round_valid),
    .ready_in (out_ready),
    .in_stage (round_stage),
    .valid_out(valid_out),
    .ready_out(renorm_ready),
    .out_stage(renorm_stage)
  );

  // Zero mantissa packs as signed zero, except on overflow which is infinity
  assign res_zero = (renorm_stage.mant == '0) && !renorm_stage.flags.overflow;
  assign res_exp = res_zero ? '0 : renorm_stage.exp;

  assign result = word_w'({renorm_stage.sign, res_exp, renorm_stage.mant[ext_w-2 -: frac_w]});
  assign flags = renorm_stage.flags;

endmodule

`default_nettype wire

/* sim/fp_adder_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_adder_checker import fp_add_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,
  input  wire fp_word_t  op_a,
  input  wire fp_word_t  op_b,
  input  wire            round_mode,
  input  wire            start,
  input  wire            in_ready,
  input  wire            valid_out,
  input  wire            out_ready,
  input  wire fp_word_t  result,
  input  wire fp_flags_t flags,
  input  wire [2:0]      test_id,
  output int             mismatches,
  output int             other_errors,
  output int             compared,
  output int             pending
);

  // Test id, result word and flags of each accepted operation
  logic [39:0] expect_q[$];

  int mismatch_count = 0;
  int other_count = 0;
  int compare_count = 0;
  int pending_count = 0;

  assign mismatches = mismatch_count;
  assign other_errors = other_count;
  assign compared = compare_count;
  assign pending = pending_count;

  function automatic string test_name(logic [2:0] id);
    case (id)
      3'd0: return "reset_first";
      3'd1: return "same_sign";
      3'd2: return "opposite_sign";
      3'd3: return "round_mode";
      3'd4: return "overflow";
      3'd5: return "back_pressure";
      default: return "unknown";
    endcase
  endfunction

  function automatic fp_stage_t normalize_model(fp_stage_t s);
    fp_stage_t r;
    r = s;
    r.carry = 1'b0;
    if (s.carry) begin
      r.mant = {1'b1, s.mant[26:1]};
      r.exp = s.exp + 8'd1;
      r.flags.inexact = s.flags.inexact | s.mant[0];
      if (r.exp == exp_max) begin
        r.mant = '0;
        r.flags.overflow = 1'b1;
        r.flags.inexact = 1'b1;
      end
    end else begin
      if (r.exp == 8'd0) begin
        r.flags.underflow = 1'b1;
        r.flags.inexact = 1'b1;
      end
      while (!r.mant[26] && r.mant != '0 && r.exp != 8'd0) begin
        r.mant = r.mant << 1;
        r.exp = r.exp - 8'd1;
        if (r.exp == 8'd0) begin
          r.flags.underflow = 1'b1;
          r.flags.inexact = 1'b1;
        end
      end
    end
    return r;
  endfunction

  function automatic logic [36:0] model_result(fp_word_t a, fp_word_t b, logic mode);
    logic [26:0] ma;
    logic [26:0] mb;
    logic [27:0] total;
    logic        rnd;
    logic        stk;
    logic        up;
    fp_stage_t   s;
    fp_word_t    w;
    ma = {1'b1, a.frac, 3'b000};
    mb = {1'b1, b.frac, 3'b000};
    s = '0;
    if (a.exp >= b.exp) begin
      s.exp = a.exp;
      mb = mb >> (a.exp - b.exp);
    end else begin
      s.exp = b.exp;
      ma = ma >> (b.exp - a.exp);
    end
    if (a.sign == b.sign) begin
      total = {1'b0, ma} + {1'b0, mb};
      {s.carry, s.mant} = total;
      s.sign = a.sign;
    end else if (ma >= mb) begin
      s.mant = ma - mb;
      s.sign = a.sign;
    end else begin
      s.mant = mb - ma;
      s.sign = b.sign;
    end
    s = normalize_model(s);
    // Round bit 2, sticky bits 1..0, last kept bit 3
    rnd = s.mant[2];
    stk = |s.mant[1:0];
    up = (mode == round_nearest_even) && rnd && (stk || s.mant[3]);
    total = {1'b0, s.mant} + {24'd0, up, 3'b000};
    {s.carry, s.mant} = total;
    s.flags.inexact = s.flags.inexact | rnd | stk;
    s = normalize_model(s);
    w.sign = s.sign;
    w.exp = (s.mant == '0 && !s.flags.overflow) ? 8'd0 : s.exp;
    w.frac = s.mant[25:3];
    return {w, s.flags};
  endfunction

  always @(posedge clk) begin : watch
    logic [39:0] entry;
    if (!rst_n) begin
      if (valid_out) begin
        other_count++;
        $display("valid_out is high during reset");
      end
    end else begin
      if (start && in_ready) begin
        expect_q.push_back({test_id, model_result(op_a, op_b, round_mode)});
      end
      if (valid_out && out_ready) begin
        if (expect_q.size() == 0) begin
          other_count++;
          $display("Result %h delivered with no operation outstanding", result);
        end else begin
          entry = expect_q.pop_front();
          compare_count++;
          if ({result, flags} !== entry[36:0]) begin
            mismatch_count++;
            $display("mismatch %s: expected %h flags %b, actual %h flags %b",
                     test_name(entry[39:37]), entry[36:5], entry[4:0], result, flags);
          end
        end
      end
    end
    pending_count = expect_q.size();
  end

endmodule

`default_nettype wire

/* sim/fp_adder_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_adder_properties import fp_add_pkg::*; (
  input wire              clk,
  input wire              rst_n,
  input wire              start,
  input wire              in_ready,
  input wire              valid_out,
  input wire              out_ready,
  input wire              align_valid,
  input wire fp_aligned_t aligned,
  input wire fp_word_t    result,
  input wire fp_flags_t   flags
);

  assert property (@(posedge clk) !rst_n |-> !valid_out)
    else $error("valid_out high while reset is asserted");

  assert property (@(posedge clk) $rose(rst_n) |-> !valid_out)
    else $error("valid_out high right after reset");

  // Held output under back-pressure
  assert property (@(posedge clk) disable iff (!rst_n)
    valid_out && !out_ready |=> valid_out && $stable(result) && $stable(flags))
    else $error("result or flags changed while out_ready was low");

  // Align register must not load a refused start
  assert property (@(posedge clk) disable iff (!rst_n)
    start && !in_ready |=> $stable(align_valid) && $stable(aligned))
    else $error("start taken while in_ready was low");

endmodule

bind fp_adder fp_adder_properties i_props (
  .clk(clk), .rst_n(rst_n), .start(start), .in_ready(in_ready),
  .valid_out(valid_out), .out_ready(out_ready), .align_valid(align_valid),
  .aligned(aligned), .result(result), .flags(flags)
);

`default_nettype wire

/* sim/tb_fp_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fp_adder import fp_add_pkg::*; ();

  localparam int clk_period = 100;
  localparam int num_ops = 400;
  localparam int max_cycles_per_op = 40;

  logic       clk;
  logic       rst_n;
  fp_word_t   op_a;
  fp_word_t   op_b;
  logic       round_mode;
  logic       start;
  logic       out_ready;
  logic       in_ready;
  logic       valid_out;
  fp_word_t   result;
  fp_flags_t  flags;
  logic [2:0] test_id;
  logic       bp_on;
  integer     seed;
  int         issued;
  int         mismatches;
  int         other_errors;
  int         compared;
  int         pending;

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  fp_adder i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_a      (op_a),
    .op_b      (op_b),
    .round_mode(round_mode),
    .start     (start),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .valid_out (valid_out),
    .result    (result),
    .flags     (flags)
  );

  fp_adder_checker i_checker (
    .clk(clk), .rst_n(rst_n), .op_a(op_a), .op_b(op_b), .round_mode(round_mode),
    .start(start), .in_ready(in_ready), .valid_out(valid_out), .out_ready(out_ready),
    .result(result), .flags(flags), .test_id(test_id), .mismatches(mismatches),
    .other_errors(other_errors), .compared(compared), .pending(pending)
  );

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // Exponent in 1..254
  function automatic logic [7:0] rand_exp();
    logic [31:0] r;
    r = $random(seed);
    return 8'(r[15:0] % 16'd254 + 16'd1);
  endfunction

  // Within 7 of e, so the guard bits come into play
  function automatic logic [7:0] near_exp(logic [7:0] e);
    logic [31:0] r;
    r = $random(seed);
    return (e > 8'd8) ? e - {5'd0, r[2:0]} : e + {5'd0, r[2:0]};
  endfunction

  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk);
    r = $random(seed);
    out_ready <= bp_on ? r[0] : 1'b1;
  endtask

  // Holds the request until the align stage takes it
  task automatic run_op(fp_word_t a, fp_word_t b, logic mode, logic [2:0] id);
    op_a <= a;
    op_b <= b;
    round_mode <= mode;
    test_id <= id;
    start <= 1'b1;
    next_cycle();
    while (!in_ready) begin
      next_cycle();
    end
    issued++;
  endtask

  initial begin
    fp_word_t    a;
    fp_word_t    b;
    logic [31:0] r;
    int          end_errors;
    seed = 32'h19b3;
    issued = 0;
    end_errors = 0;
    bp_on = 1'b0;
    rst_n = 1'b0;
    op_a = '0;
    op_b = '0;
    round_mode = round_nearest_even;
    start = 1'b0;
    out_ready = 1'b1;
    test_id = 3'd0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    next_cycle();
    // 1.5 + 2.25 right out of reset
    run_op(32'h3fc00000, 32'h40100000, round_nearest_even, 3'd0);

    for (int i = 0; i < 100; i++) begin
      a = rand_word();
      b = rand_word();
      r = rand_word();
      a.exp = rand_exp();
      b.sign = a.sign;
      b.exp = (i % 2 == 1) ? rand_exp() : near_exp(a.exp);
      run_op(a, b, r[0], 3'd1);
    end

    // Close magnitudes make the normalizer shift many times
    for (int i = 0; i < 100; i++) begin
      a = rand_word();
      b = rand_word();
      r = rand_word();
      a.exp = rand_exp();
      if (i % 10 == 0) begin
        b = a;
      end else if (i % 3 == 1) begin
        b.exp = a.exp;
        b.frac = a.frac ^ {15'd0, r[8:1]};
      end else begin
        b.exp = near_exp(a.exp);
      end
      b.sign = !a.sign;
      run_op(a, b, r[0], 3'd2);
    end

    bp_on = 1'b1;
    for (int i = 0; i < 50; i++) begin
      a = rand_word();
      b = rand_word();
      a.exp = rand_exp();
      b.exp = near_exp(a.exp);
      run_op(a, b, round_nearest_even, 3'd3);
      run_op(a, b, round_zero, 3'd3);
    end

    for (int i = 0; i < 20; i++) begin
      a = rand_word();
      b = rand_word();
      r = rand_word();
      a.exp = 8'd254;
      b.exp = (i % 2 == 1) ? 8'd254 : 8'd253;
      // Top fraction bits set so the sum always carries
      a.frac[frac_w-1] = 1'b1;
      b.frac[frac_w-1] = 1'b1;
      b.sign = a.sign;
      run_op(a, b, r[0], 3'd4);
    end

    for (int i = 0; i < 79; i++) begin
      a = rand_word();
      b = rand_word();
      r = rand_word();
      a.exp = rand_exp();
      b.exp = rand_exp();
      run_op(a, b, r[0], 3'd5);
    end
    start <= 1'b0;

    next_cycle();
    while (compared < issued) begin
      next_cycle();
    end
    repeat (10) next_cycle();
    if (compared != issued || pending != 0) begin
      end_errors++;
      $display("Result count wrong: %0d issued, %0d compared, %0d still queued",
               issued, compared, pending);
    end
    $display("Error counts: %0d mismatches, %0d other, %0d at end of run (%0d results)",
             mismatches, other_errors, end_errors, compared);
    if (mismatches == 0 && other_errors == 0 && end_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(num_ops * max_cycles_per_op * clk_period);
    $display("Timeout: results still missing after %0d cycles",
             num_ops * max_cycles_per_op);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
src/fp_add_pkg.sv
src/fp_align.sv
src/fp_addsub.sv
src/fp_normalize.sv
src/fp_round.sv
src/fp_adder.sv
sim/fp_adder_checker.sv
sim/fp_adder_properties.sv
sim/tb_fp_adder.sv

/* run.sh */
#!/bin/sh
rm -f sim.log \
  && verilator --binary --timing --assert --top-module tb_fp_adder -f tb.f -o sim_fp_adder \
  && ./obj_dir/sim_fp_adder | tee sim.log \
  && grep -qx "Test completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
